// File: design/softermax_defs.svh
// widths are tied to the pow2 table and the divider; change them only as a set.
`ifndef SOFTERMAX_DEFS_SVH
`define SOFTERMAX_DEFS_SVH

// ----------------------------------------
// vector shape
// ----------------------------------------
`define SOFTERMAX_VEC_LEN 10 // elements per vector.

// ----------------------------------------
// fixed-point formats
// ----------------------------------------
// input samples are signed Q4.4.
`define SOFTERMAX_IN_WIDTH 8
`define SOFTERMAX_IN_FRAC 4

`define SOFTERMAX_POW2_WIDTH 8 // unsigned Q1.7 power of two.

// running sum in Q5.7, large enough for ten full-scale terms.
`define SOFTERMAX_SUM_WIDTH 12

`define SOFTERMAX_OUT_WIDTH 8 // unsigned Q1.7 probability.

`endif

// File: design/softermax_pkg.sv
// types only; widths come from the shared defines, so include that header first.
`include "softermax_defs.svh"

package softermax_pkg;

    // ----------------------------------------
    // datapath words
    // ----------------------------------------
    typedef logic signed [`SOFTERMAX_IN_WIDTH-1:0] in_data_t; // Q4.4 sample.

    // integer part of a sample, used for the running max.
    typedef logic signed [`SOFTERMAX_IN_WIDTH-`SOFTERMAX_IN_FRAC-1:0] int_part_t;

    typedef logic [`SOFTERMAX_POW2_WIDTH-1:0] pow2_t; // Q1.7.
    typedef logic [`SOFTERMAX_SUM_WIDTH-1:0] sum_t; // Q5.7.
    typedef logic [`SOFTERMAX_OUT_WIDTH-1:0] out_data_t; // Q1.7.

    // element index within a vector.
    typedef logic [$clog2(`SOFTERMAX_VEC_LEN)-1:0] count_t;

    // ----------------------------------------
    // normaliser FSM
    // ----------------------------------------
    typedef enum logic {
        NORM_ACCUM, // taking in a vector.
        NORM_DRAIN // feeding the divider.
    } norm_state_t;

endpackage

// File: design/softermax_if.sv
// valid/ready streams between stages; data and valid hold until ready is seen.
`timescale 1ns/1ps

// local window to global norm.
interface softermax_pow2_if;
    softermax_pkg::pow2_t value; // 2^(x - M).
    softermax_pkg::int_part_t max; // running max at this element.
    logic last;
    logic valid;
    logic ready;

    modport source (
        output value, max, last, valid,
        input ready
    );

    modport sink (
        input value, max, last, valid,
        output ready
    );
endinterface

// global norm to divider.
interface softermax_div_if;
    softermax_pkg::pow2_t dividend; // aligned term.
    softermax_pkg::sum_t divisor; // final vector sum.
    logic last;
    logic valid;
    logic ready;

    modport source (
        output dividend, divisor, last, valid,
        input ready
    );

    modport sink (
        input dividend, divisor, last, valid,
        output ready
    );
endinterface

// File: design/softermax_pow2_lut.sv
// expects diff at most 15; anything at or below -128 must already be clamped to -128.
`timescale 1ns/1ps
`include "softermax_defs.svh"

module softermax_pow2_lut (
    input softermax_pkg::in_data_t diff,
    output softermax_pkg::pow2_t pow2
);

    softermax_pkg::int_part_t int_part;
    logic [`SOFTERMAX_IN_FRAC-1:0] frac;
    logic [`SOFTERMAX_IN_WIDTH-`SOFTERMAX_IN_FRAC-1:0] shamt;
    softermax_pkg::pow2_t frac_pow;

    assign int_part = diff[`SOFTERMAX_IN_WIDTH-1:`SOFTERMAX_IN_FRAC];
    assign frac = diff[`SOFTERMAX_IN_FRAC-1:0];
    assign shamt = -int_part; // -8 comes out as 8.

    // round(128 * 2^(f/16)).
    always_comb begin
        unique case (frac)
            4'd0: frac_pow = 8'd128;
            4'd1: frac_pow = 8'd134;
            4'd2: frac_pow = 8'd140;
            4'd3: frac_pow = 8'd146;
            4'd4: frac_pow = 8'd152;
            4'd5: frac_pow = 8'd159;
            4'd6: frac_pow = 8'd166;
            4'd7: frac_pow = 8'd173;
            4'd8: frac_pow = 8'd181;
            4'd9: frac_pow = 8'd189;
            4'd10: frac_pow = 8'd197;
            4'd11: frac_pow = 8'd206;
            4'd12: frac_pow = 8'd215;
            4'd13: frac_pow = 8'd225;
            4'd14: frac_pow = 8'd235;
            4'd15: frac_pow = 8'd245;
        endcase
    end

    // shifts of 8 or more flush the value to zero.
    assign pow2 = frac_pow >> shamt;

endmodule

// File: design/softermax_local_window.sv
// one element per beat; vectors are exactly SOFTERMAX_VEC_LEN long with no framing input.
`timescale 1ns/1ps
`include "softermax_defs.svh"

module softermax_local_window (
    input logic clk,
    input logic reset,
    input softermax_pkg::in_data_t in_data,
    input logic in_valid,
    output logic in_ready,
    softermax_pow2_if.source out_stream
);

    localparam softermax_pkg::count_t LAST_IDX =
        softermax_pkg::count_t'(`SOFTERMAX_VEC_LEN - 1);
    localparam softermax_pkg::in_data_t DIFF_FLOOR =
        {1'b1, {(`SOFTERMAX_IN_WIDTH-1){1'b0}}};

    softermax_pkg::count_t count;
    softermax_pkg::int_part_t run_max;
    softermax_pkg::int_part_t in_int;
    softermax_pkg::int_part_t new_max;
    logic signed [`SOFTERMAX_IN_WIDTH:0] diff_wide;
    softermax_pkg::in_data_t diff;
    softermax_pkg::pow2_t pow2;
    logic in_fire;

    // ----------------------------------------
    // running max and difference
    // ----------------------------------------
    assign in_int = in_data[`SOFTERMAX_IN_WIDTH-1:`SOFTERMAX_IN_FRAC]; // floor(x).

    // first element of a vector restarts the max.
    assign new_max = (count == '0 || in_int > run_max) ? in_int : run_max;

    assign diff_wide = in_data - $signed({new_max, {`SOFTERMAX_IN_FRAC{1'b0}}});

    // only the negative side can overflow.
    assign diff = (diff_wide[`SOFTERMAX_IN_WIDTH] != diff_wide[`SOFTERMAX_IN_WIDTH-1]) ?
        DIFF_FLOOR : diff_wide[`SOFTERMAX_IN_WIDTH-1:0];

    softermax_pow2_lut pow2_lut (
        .diff (diff),
        .pow2 (pow2)
    );

    // ----------------------------------------
    // output register
    // ----------------------------------------
    assign in_ready = ~out_stream.valid | out_stream.ready;
    assign in_fire = in_valid & in_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
            out_stream.valid <= 1'b0;
        end else begin
            if (in_fire) begin
                count <= (count == LAST_IDX) ? '0 : count + 1'b1;
                out_stream.valid <= 1'b1;
            end else if (out_stream.ready) begin
                out_stream.valid <= 1'b0; // drained.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_fire) begin
            run_max <= new_max;
            out_stream.value <= pow2;
            out_stream.max <= new_max;
            out_stream.last <= (count == LAST_IDX);
        end
    end

endmodule

// File: design/softermax_global_norm.sv
// buffers one whole vector and blocks input while it drains toward the divider.
`timescale 1ns/1ps
`include "softermax_defs.svh"

module softermax_global_norm (
    input logic clk,
    input logic reset,
    softermax_pow2_if.sink in_stream,
    softermax_div_if.source out_stream
);

    localparam softermax_pkg::count_t LAST_IDX =
        softermax_pkg::count_t'(`SOFTERMAX_VEC_LEN - 1);

    softermax_pkg::norm_state_t state;
    softermax_pkg::count_t wr_idx;
    softermax_pkg::count_t rd_idx;

    softermax_pkg::pow2_t buf_p [`SOFTERMAX_VEC_LEN];
    softermax_pkg::int_part_t buf_m [`SOFTERMAX_VEC_LEN];

    softermax_pkg::int_part_t cur_max; // max of the last element taken.
    softermax_pkg::sum_t sum;
    softermax_pkg::sum_t sum_scaled;
    logic signed [`SOFTERMAX_IN_WIDTH-`SOFTERMAX_IN_FRAC:0] max_step;
    logic signed [`SOFTERMAX_IN_WIDTH-`SOFTERMAX_IN_FRAC:0] align_step;

    logic in_fire;
    logic out_fire;

    // ----------------------------------------
    // handshakes
    // ----------------------------------------
    assign in_stream.ready = (state == softermax_pkg::NORM_ACCUM);
    assign out_stream.valid = (state == softermax_pkg::NORM_DRAIN);

    assign in_fire = in_stream.valid & in_stream.ready;
    assign out_fire = out_stream.valid & out_stream.ready;

    // ----------------------------------------
    // running sum
    // ----------------------------------------
    // the max never falls inside a vector, so the step is never negative.
    assign max_step = in_stream.max - cur_max;

    always_comb begin
        if (max_step > 0) begin
            sum_scaled = sum >> max_step[`SOFTERMAX_IN_WIDTH-`SOFTERMAX_IN_FRAC-1:0];
        end else begin
            sum_scaled = sum;
        end
    end

    // ----------------------------------------
    // drain alignment
    // ----------------------------------------
    assign align_step = cur_max - buf_m[rd_idx];

    // q = p >> (final max - element max).
    assign out_stream.dividend =
        buf_p[rd_idx] >> align_step[`SOFTERMAX_IN_WIDTH-`SOFTERMAX_IN_FRAC-1:0];
    assign out_stream.divisor = sum;
    assign out_stream.last = (rd_idx == LAST_IDX);

    // ----------------------------------------
    // FSM and indices
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= softermax_pkg::NORM_ACCUM;
            wr_idx <= '0;
            rd_idx <= '0;
        end else begin
            unique case (state)
                softermax_pkg::NORM_ACCUM: begin
                    if (in_fire) begin
                        if (in_stream.last) begin
                            state <= softermax_pkg::NORM_DRAIN;
                            wr_idx <= '0;
                            rd_idx <= '0;
                        end else begin
                            wr_idx <= wr_idx + 1'b1;
                        end
                    end
                end
                softermax_pkg::NORM_DRAIN: begin
                    if (out_fire) begin
                        if (out_stream.last) begin
                            state <= softermax_pkg::NORM_ACCUM; // vector done.
                        end else begin
                            rd_idx <= rd_idx + 1'b1;
                        end
                    end
                end
            endcase
        end
    end

    // buffer, sum and max update on every accepted element.
    always_ff @(posedge clk) begin
        if (in_fire) begin
            buf_p[wr_idx] <= in_stream.value;
            buf_m[wr_idx] <= in_stream.max;
            cur_max <= in_stream.max;
            if (wr_idx == '0) begin
                sum <= softermax_pkg::sum_t'(in_stream.value); // fresh vector.
            end else begin
                sum <= sum_scaled + softermax_pkg::sum_t'(in_stream.value);
            end
        end
    end

endmodule

// File: design/softermax_divider.sv
// needs dividend < 2*divisor so the quotient fits in 8 bits; one item in flight at a time.
`timescale 1ns/1ps
`include "softermax_defs.svh"

module softermax_divider (
    input logic clk,
    input logic reset,
    softermax_div_if.sink in_stream,
    output softermax_pkg::out_data_t out_data,
    output logic out_valid,
    output logic out_last,
    input logic out_ready
);

    localparam int REM_W = `SOFTERMAX_SUM_WIDTH + 1;
    localparam int ITER_W = $clog2(`SOFTERMAX_OUT_WIDTH);
    localparam logic [ITER_W-1:0] LAST_ITER = ITER_W'(`SOFTERMAX_OUT_WIDTH - 1);

    logic busy;
    logic [ITER_W-1:0] iter;
    logic [REM_W-1:0] rem;
    logic [REM_W-1:0] rem_sub;
    logic [REM_W-1:0] divisor_ext;
    softermax_pkg::sum_t divisor_q;
    softermax_pkg::out_data_t quot;
    logic last_q;
    logic take;
    logic in_fire;

    // idle means neither iterating nor holding a result.
    assign in_stream.ready = ~busy & ~out_valid;
    assign in_fire = in_stream.valid & in_stream.ready;

    // ----------------------------------------
    // one restoring step per cycle
    // ----------------------------------------
    assign divisor_ext = {1'b0, divisor_q};
    assign take = (rem >= divisor_ext); // next quotient bit.
    assign rem_sub = take ? rem - divisor_ext : rem;

    assign out_data = quot;
    assign out_last = last_q & out_valid; // low while nothing is held.

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            iter <= '0;
            out_valid <= 1'b0;
        end else begin
            if (in_fire) begin
                busy <= 1'b1;
                iter <= '0;
            end else if (busy) begin
                iter <= iter + 1'b1;
                if (iter == LAST_ITER) begin
                    busy <= 1'b0;
                    out_valid <= 1'b1; // quotient complete.
                end
            end else if (out_valid && out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    // first bit weighs 2^7, so start from q rather than q*128.
    always_ff @(posedge clk) begin
        if (in_fire) begin
            rem <= REM_W'(in_stream.dividend);
            divisor_q <= in_stream.divisor;
            last_q <= in_stream.last;
        end else if (busy) begin
            rem <= {rem_sub[REM_W-2:0], 1'b0};
            quot <= {quot[`SOFTERMAX_OUT_WIDTH-2:0], take};
        end
    end

endmodule

// File: design/fixed_softermax.sv
// single row, one element per beat; output latency varies with back-pressure.
`timescale 1ns/1ps

module fixed_softermax (
    input logic clk,
    input logic reset,

    input softermax_pkg::in_data_t data_in,
    input logic data_in_valid,
    output logic data_in_ready,

    output softermax_pkg::out_data_t data_out,
    output logic data_out_valid,
    output logic data_out_last,
    input logic data_out_ready
);

    softermax_pow2_if pow2_bus ();
    softermax_div_if div_bus ();

    // ----------------------------------------
    // stage 1, running max and power of two
    // ----------------------------------------
    softermax_local_window local_window (
        .clk (clk),
        .reset (reset),
        .in_data (data_in),
        .in_valid (data_in_valid),
        .in_ready (data_in_ready),
        .out_stream (pow2_bus.source)
    );

    // stage 2, buffer and normalise.
    softermax_global_norm global_norm (
        .clk (clk),
        .reset (reset),
        .in_stream (pow2_bus.sink),
        .out_stream (div_bus.source)
    );

    // stage 3, q * 128 / S.
    softermax_divider divider (
        .clk (clk),
        .reset (reset),
        .in_stream (div_bus.sink),
        .out_data (data_out),
        .out_valid (data_out_valid),
        .out_last (data_out_last),
        .out_ready (data_out_ready)
    );

endmodule

// File: tests/fixed_softermax_sva.sv
// bound to the top level; sampled on the rising clock edge, checks pause while reset is high.
`timescale 1ns/1ps

module fixed_softermax_sva (
    input logic clk,
    input logic reset,
    input softermax_pkg::out_data_t data_out,
    input logic data_out_valid,
    input logic data_out_last,
    input logic data_out_ready
);

    int assert_fail_count = 0; // failed assertions so far.

    // nothing comes out right after reset.
    no_valid_after_reset: assert property (
        @(posedge clk) reset |=> !data_out_valid
    ) else begin
        $error("data_out_valid high in the cycle after reset");
        assert_fail_count++;
    end

    // a stalled result holds until it is taken.
    hold_while_stalled: assert property (
        @(posedge clk) disable iff (reset)
        (data_out_valid && !data_out_ready) |=>
            (data_out_valid && $stable(data_out) && $stable(data_out_last))
    ) else begin
        $error("data_out or data_out_last changed while stalled");
        assert_fail_count++;
    end

    prob_in_range: assert property (
        @(posedge clk) disable iff (reset)
        data_out_valid |-> (data_out <= 8'd128) // 1.0 in Q1.7.
    ) else begin
        $error("data_out above 128");
        assert_fail_count++;
    end

endmodule

bind fixed_softermax fixed_softermax_sva protocol_checks (
    .clk (clk),
    .reset (reset),
    .data_out (data_out),
    .data_out_valid (data_out_valid),
    .data_out_last (data_out_last),
    .data_out_ready (data_out_ready)
);

// File: tests/fixed_softermax_tb.sv
// golden file path is relative to the project root, so start the simulator from there.
`timescale 1ns/1ps
`include "softermax_defs.svh"

module fixed_softermax_tb;

    localparam int NUM_VECS = 4;
    localparam int NUM_ELEMS = NUM_VECS * `SOFTERMAX_VEC_LEN;
    localparam int TIMEOUT_CYCLES = NUM_ELEMS * 40 + 200;

    logic clk;
    logic reset;
    softermax_pkg::in_data_t data_in;
    logic data_in_valid;
    logic data_in_ready;
    softermax_pkg::out_data_t data_out;
    logic data_out_valid;
    logic data_out_last;
    logic data_out_ready;

    logic [15:0] golden [NUM_ELEMS]; // {input sample, expected output}.

    int mismatch_count;
    int failure_count;
    int sent_count;
    int recv_count;
    int last_count;
    int stall_count; // beats held off by data_in_ready.

    fixed_softermax DUT (
        .clk (clk),
        .reset (reset),
        .data_in (data_in),
        .data_in_valid (data_in_valid),
        .data_in_ready (data_in_ready),
        .data_out (data_out),
        .data_out_valid (data_out_valid),
        .data_out_last (data_out_last),
        .data_out_ready (data_out_ready)
    );

    always #5 clk = ~clk;

    // ----------------------------------------
    // checking and end of run
    // ----------------------------------------
    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            mismatch_count++;
        end
    endtask

    task automatic finish_run();
        failure_count += DUT.protocol_checks.assert_fail_count; // bound checker failures.
        $display("Errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    // random back-pressure on the output, about one stall in four.
    always @(posedge clk) begin
        if (reset) begin
            data_out_ready <= 1'b0;
        end else begin
            data_out_ready <= (($urandom % 4) != 0);
        end
    end

    // results in order, taken at the edge where the handshake completes.
    always @(posedge clk) begin
        if (!reset && data_out_valid && data_out_ready) begin
            if (recv_count < NUM_ELEMS) begin
                check_value("data_out", data_out, golden[recv_count][7:0]);
                check_value("data_out_last", data_out_last,
                    (recv_count % `SOFTERMAX_VEC_LEN) == `SOFTERMAX_VEC_LEN - 1);
            end else begin
                $display("Error: DUT gave an output beyond the %0d expected", NUM_ELEMS);
                failure_count++;
            end
            if (data_out_last) begin
                last_count++;
            end
            recv_count++;
        end
    end

    // ----------------------------------------
    // stimulus
    // ----------------------------------------
    initial begin
        int unsigned seed_value;
        int unsigned gap;
        seed_value = $urandom(35889);
        clk = 1'b0;
        reset = 1'b1;
        data_in = '0;
        data_in_valid = 1'b0;
        data_out_ready = 1'b0;
        mismatch_count = 0;
        failure_count = 0;
        sent_count = 0;
        recv_count = 0;
        last_count = 0;
        stall_count = 0;
        $readmemh("tests/softermax_golden.mem", golden);

        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_value("data_out_valid", data_out_valid, 1'b0); // idle after reset.
        check_value("data_out_last", data_out_last, 1'b0);
        check_value("data_in_ready", data_in_ready, 1'b1);

        @(posedge clk);
        for (int i = 0; i < NUM_ELEMS; i++) begin
            gap = (($urandom % 4) == 0) ? ($urandom % 3) + 1 : 0;
            if (gap > 0) begin
                data_in_valid <= 1'b0;
                repeat (gap) @(posedge clk);
            end
            data_in <= golden[i][15:8];
            data_in_valid <= 1'b1;
            @(posedge clk);
            while (!data_in_ready) begin
                stall_count++;
                @(posedge clk);
            end
            sent_count++;
        end
        data_in_valid <= 1'b0;

        wait (recv_count >= NUM_ELEMS);
        repeat (20) @(posedge clk); // room for any stray extra output.
        check_value("output_count", recv_count, sent_count);
        check_value("last_count", last_count, NUM_VECS);
        if (stall_count == 0) begin
            $display("Error: data_in_ready never held off the input stream");
            failure_count++;
        end
        finish_run();
    end

    // watchdog.
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Error: run timed out after %0d cycles with %0d of %0d outputs received",
            TIMEOUT_CYCLES, recv_count, NUM_ELEMS);
        failure_count++;
        finish_run();
    end

endmodule

// File: tests/softermax_golden.mem
// each word is {input sample, expected output}, one hex byte each, one element per line.
// input is signed Q4.4, output unsigned Q1.7; ten lines per vector, four vectors.
100c
100c
100c
100c
100c
100c
100c
100c
100c
100c
0002
0804
1808
1005
2c13
0403
3f2c
f001
3017
240d
8000
9a00
c500
8500
0000
e800
5a0e
7f4a
7026
8100
4711
3c0a
2e05
410d
1201
ff00
4b14
5019
3307
4f18

// File: sim.f
+incdir+design
design/softermax_pkg.sv
design/softermax_if.sv
design/softermax_pow2_lut.sv
design/softermax_local_window.sv
design/softermax_global_norm.sv
design/softermax_divider.sv
design/fixed_softermax.sv
tests/fixed_softermax_sva.sv
tests/fixed_softermax_tb.sv
